/* block_stats_top.f */
rtl/stat_types_pkg.sv
rtl/stat_ctrl_pkg.sv
rtl/mean_accumulator.sv
rtl/sample_bank.sv
rtl/sample_replay.sv
rtl/variance_unit.sv
rtl/block_stats_top.sv
testbench/block_stats_tb.sv

/* Makefile */
# Verilator build and run for the block statistics testbench

TOP  := block_stats_tb
BIN  := obj_dir/V$(TOP)
SRCS := $(shell cat block_stats_top.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): block_stats_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f block_stats_top.f

# Passes only if the output holds the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* testbench/block_stats_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block statistics testbench
// Drives directed, back to back, gapped and reset-interrupted blocks
// into the DUT. Expected mean and variance come from a reference model.
// The monitor checks values, order and the T+5 cycle result latency.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module block_stats_tb
	import stat_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int T          = 16;     // Block length
	localparam int RST_CYCLES = 4;
	localparam int N_RANDOM   = 4;      // Blocks per random phase
	localparam int N_BLOCKS   = 2 + 2 * N_RANDOM + 1; // Full blocks driven, partial one excluded
	localparam int GAP_MAX    = 4;      // Longest idle gap in the gapped phase
	localparam int PARTIAL    = 7;      // Samples before the mid-block reset
	localparam int DRAIN      = T + 8;  // Worst wait for the pipeline to empty
	localparam int STIM_CYCLES = 2 * RST_CYCLES + (2 + N_RANDOM + 1) * T
		+ N_RANDOM * T * (1 + GAP_MAX) + PARTIAL + 3 * DRAIN + 8;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;

	// One expected result
	typedef struct packed {
		int unsigned due;      // Monitor cycle in which stats_valid must be high
		mean_t       mean;
		var_t        variance;
	} expect_t;

	logic    clk;
	logic    rst_n;
	logic    sample_valid;
	sample_t sample;
	logic    stats_valid;
	mean_t   mean_out;
	var_t    variance_out;

	logic [15:0] lfsr_state = 16'd52;   // Seed
	expect_t     expect_q [$];          // Completed blocks, oldest first
	sample_t     blk_buf [T];           // Samples of the block being collected
	int          blk_count    = 0;
	int          blocks_done  = 0;
	int          results_seen = 0;
	int unsigned cycle_count  = 0;      // Advances every falling edge

	block_stats_top #(.TOTAL_SAMPLES(T)) i_block_stats_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.sample       (sample),
		.stats_valid  (stats_valid),
		.mean_out     (mean_out),
		.variance_out (variance_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// x^16 + x^14 + x^13 + x^11 + 1, shifts towards the MSB
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// One LFSR step per bit, MSB first
	task automatic take_bits(input int n, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value      = {value[6:0], lfsr_state[15]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Floor mean, then floor of summed squared deviations over T
	function automatic expect_t block_reference(input sample_t blk [T], input int unsigned due);
		int unsigned sum;
		int unsigned sq_sum;
		int          diff;
		expect_t     e;
		sum    = 0;
		sq_sum = 0;
		for (int i = 0; i < T; i++) begin
			sum = sum + int'(blk[i]);
		end
		e.mean = mean_t'(sum / T);
		for (int i = 0; i < T; i++) begin
			diff   = int'(blk[i]) - int'(e.mean);
			sq_sum = sq_sum + int'(diff * diff);
		end
		e.variance = var_t'(sq_sum / T);
		e.due      = due;
		return e;
	endfunction

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic drive_sample(input sample_t value);
		@(posedge clk);
		#2;
		sample_valid = 1'b1;
		sample       = value;
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
			sample_valid = 1'b0;
		end
	endtask

	task automatic send_constant_block(input sample_t value);
		repeat (T) drive_sample(value);
	endtask

	task automatic send_alternating_block();
		for (int i = 0; i < T; i++) begin
			drive_sample((i % 2 == 0) ? 8'd0 : 8'd255);
		end
	endtask

	// Random samples, optionally with random idle gaps in front
	task automatic send_random_block(input logic gaps);
		logic [7:0] value;
		logic [7:0] gap_on;
		logic [7:0] gap_len;
		for (int i = 0; i < T; i++) begin
			take_bits(8, value);
			if (gaps) begin
				take_bits(1, gap_on);
				if (gap_on[0]) begin
					take_bits(2, gap_len);
					drive_idle(int'(gap_len) + 1); // 1 to GAP_MAX cycles
				end
			end
			drive_sample(value);
		end
	endtask

	// Partial block, then a reset of RST_CYCLES cycles
	task automatic reset_mid_block(input int partial);
		logic [7:0] value;
		for (int i = 0; i < partial; i++) begin
			take_bits(8, value);
			drive_sample(value);
		end
		@(posedge clk);
		#2;
		rst_n        = 1'b0;
		sample_valid = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	task automatic wait_for_drain();
		while (expect_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	// Monitor and checker, samples at the falling edge where all is stable
	always @(negedge clk) begin : monitor
		expect_t got;
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			stop_on_failure($sformatf("Timeout: run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
		if (!rst_n) begin
			blk_count = 0; // Partial block is lost
			assert (!stats_valid) else
				stop_on_failure($sformatf("Error at %0t: stats_valid high during reset", $time));
		end else begin
			if (sample_valid) begin
				blk_buf[blk_count] = sample;
				if (blk_count == T - 1) begin
					expect_q.push_back(block_reference(blk_buf, cycle_count + T + 5));
					blocks_done = blocks_done + 1;
					blk_count   = 0;
				end else begin
					blk_count = blk_count + 1;
				end
			end
			if (stats_valid) begin
				assert (expect_q.size() > 0) else
					stop_on_failure("stats_valid pulsed with no completed block outstanding");
				got = expect_q.pop_front();
				results_seen = results_seen + 1;
				assert (cycle_count == got.due) else
					stop_on_failure($sformatf("Error at %0t: result %0d cycles late",
						$time, int'(cycle_count) - int'(got.due)));
				assert (mean_out == got.mean) else
					stop_on_failure($sformatf("Error at %0t: mean_out %0d, expected %0d",
						$time, mean_out, got.mean));
				assert (variance_out == got.variance) else
					stop_on_failure($sformatf("Error at %0t: variance_out %0d, expected %0d",
						$time, variance_out, got.variance));
			end else if (expect_q.size() > 0) begin
				assert (expect_q[0].due != cycle_count) else
					stop_on_failure($sformatf("Error at %0t: expected result did not arrive",
						$time));
			end
		end
	end

	initial begin : stimulus
		$timeformat(-9, 1, " ns", 0);
		rst_n        = 1'b0;
		sample_valid = 1'b0;
		sample       = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		drive_idle(3);

		send_constant_block(8'd93);  // Mean 93, variance 0
		send_alternating_block();    // Mean 127, variance 16256

		repeat (N_RANDOM) send_random_block(1'b0); // Banks alternate, blocks overlap
		drive_idle(1);
		repeat (N_RANDOM) send_random_block(1'b1);
		drive_idle(1);
		wait_for_drain();

		reset_mid_block(PARTIAL);
		send_random_block(1'b0);     // First full block after reset
		drive_idle(1);
		wait_for_drain();

		assert (results_seen == N_BLOCKS && blocks_done == N_BLOCKS) else
			stop_on_failure($sformatf("Error at %0t: %0d results for %0d blocks, %0d driven",
				$time, results_seen, blocks_done, N_BLOCKS));
		$display("TEST PASS");
		$finish;
	end

endmodule

/* rtl/block_stats_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block statistics top level
// Mean and population variance over blocks of TOTAL_SAMPLES samples.
// Mean stage, ping-pong sample store, replay and variance pipeline.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module block_stats_top
	import stat_types_pkg::*;
	import stat_ctrl_pkg::*;
#(
	parameter int TOTAL_SAMPLES = 64 // Power of two, at least 4
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    sample_valid,
	input  sample_t sample,
	output logic    stats_valid,  // T+5 cycles after the last sample
	output mean_t   mean_out,
	output var_t    variance_out
);

	localparam int ADDR_W = $clog2(TOTAL_SAMPLES);

	// Mean stage to store and replay
	logic              wr_en;
	bank_t             wr_bank;
	logic [ADDR_W-1:0] wr_addr;
	sample_t           wr_data;
	logic              block_done;
	mean_t             block_mean;
	bank_t             block_bank;

	// Replay to store and variance unit
	bank_t             rd_bank;
	logic [ADDR_W-1:0] rd_addr;
	sample_t           rd_data;
	logic              diff_valid;
	logic              diff_first;
	logic              diff_last;
	mean_t             diff_mean;

	mean_accumulator #(.TOTAL_SAMPLES(TOTAL_SAMPLES)) i_mean_accumulator (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.sample       (sample),
		.wr_en        (wr_en),
		.wr_bank      (wr_bank),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.block_done   (block_done),
		.block_mean   (block_mean),
		.block_bank   (block_bank)
	);

	sample_bank #(.TOTAL_SAMPLES(TOTAL_SAMPLES)) i_sample_bank (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	sample_replay #(.TOTAL_SAMPLES(TOTAL_SAMPLES)) i_sample_replay (
		.clk        (clk),
		.rst_n      (rst_n),
		.block_done (block_done),
		.block_mean (block_mean),
		.block_bank (block_bank),
		.rd_bank    (rd_bank),
		.rd_addr    (rd_addr),
		.diff_valid (diff_valid),
		.diff_first (diff_first),
		.diff_last  (diff_last),
		.diff_mean  (diff_mean)
	);

	variance_unit #(.TOTAL_SAMPLES(TOTAL_SAMPLES)) i_variance_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.diff_valid   (diff_valid),
		.diff_first   (diff_first),
		.diff_last    (diff_last),
		.diff_mean    (diff_mean),
		.data_in      (rd_data),      // Straight from the bank read port
		.mean_out     (mean_out),
		.variance_out (variance_out),
		.stats_valid  (stats_valid)
	);

endmodule

/* rtl/variance_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variance unit
// Three stage pipeline: signed difference against the block mean,
// square, then accumulate. The first sample of a block loads the
// accumulator, the last one registers mean and variance and pulses
// stats_valid. Tags travel per stage so two blocks may overlap.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module variance_unit
	import stat_types_pkg::*;
#(
	parameter int TOTAL_SAMPLES = 64
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    diff_valid,
	input  logic    diff_first,   // First sample of a block
	input  logic    diff_last,    // Last sample of a block
	input  mean_t   diff_mean,
	input  sample_t data_in,      // Replayed sample from the bank
	output mean_t   mean_out,
	output var_t    variance_out,
	output logic    stats_valid   // One-cycle result pulse
);

	localparam int ADDR_W = $clog2(TOTAL_SAMPLES);
	localparam int SQ_W   = $bits(square_t);
	localparam int ACC_W  = SQ_W + ADDR_W;                 // Holds T * 65025
	localparam longint unsigned ACC_MAX = longint'(TOTAL_SAMPLES) * 65025;

	// Stage 1 difference
	logic  s1_valid, s1_first, s1_last;
	mean_t s1_mean;
	diff_t s1_diff;

	// Stage 2 square
	logic    s2_valid, s2_first, s2_last;
	mean_t   s2_mean;
	square_t s2_square;

	logic signed [2*$bits(diff_t)-1:0] sq_full; // Full signed product
	logic [ACC_W-1:0]                  acc;
	logic [ACC_W-1:0]                  acc_next;

	assign sq_full  = s1_diff * s1_diff;
	assign acc_next = s2_first ? ACC_W'(s2_square) : acc + ACC_W'(s2_square);

	// Tag pipeline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid    <= 1'b0;
			s1_first    <= 1'b0;
			s1_last     <= 1'b0;
			s2_valid    <= 1'b0;
			s2_first    <= 1'b0;
			s2_last     <= 1'b0;
			stats_valid <= 1'b0;
		end else begin
			s1_valid    <= diff_valid;
			s1_first    <= diff_valid && diff_first;
			s1_last     <= diff_valid && diff_last;
			s2_valid    <= s1_valid;
			s2_first    <= s1_first;
			s2_last     <= s1_last;
			stats_valid <= s2_valid && s2_last;
		end
	end

	// Datapath of stages 1 and 2
	always_ff @(posedge clk) begin
		s1_mean   <= diff_mean;
		s1_diff   <= $signed({1'b0, data_in}) - $signed({1'b0, diff_mean});
		s2_mean   <= s1_mean;
		s2_square <= square_t'(sq_full); // Non-negative, top bits are zero
	end

	// Stage 3 accumulate
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (s2_valid) begin
			acc <= acc_next;
		end
	end

	// Results held until the next block finishes
	always_ff @(posedge clk) begin
		if (s2_valid && s2_last) begin
			mean_out     <= s2_mean;
			variance_out <= acc_next[ACC_W-1 -: SQ_W]; // Divide by T
		end
	end

	// A block is exactly T samples, each square at most 255 * 255
	a_acc_bound: assert property (@(posedge clk) disable iff (!rst_n)
		acc <= ACC_MAX);

endmodule

/* rtl/sample_replay.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample replay sequencer
// On block_done it latches the block mean and bank, then reads the
// bank from address 0 to TOTAL_SAMPLES-1. The valid, first and last
// tags are delayed one cycle to line up with the bank read data.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sample_replay
	import stat_types_pkg::*;
	import stat_ctrl_pkg::*;
#(
	parameter int TOTAL_SAMPLES = 64
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             block_done,
	input  mean_t                            block_mean,
	input  bank_t                            block_bank,
	output bank_t                            rd_bank,
	output logic [$clog2(TOTAL_SAMPLES)-1:0] rd_addr,
	output logic                             diff_valid, // Aligned with rd_data
	output logic                             diff_first,
	output logic                             diff_last,
	output mean_t                            diff_mean
);

	localparam int ADDR_W = $clog2(TOTAL_SAMPLES);

	replay_state_e state;
	mean_t         held_mean; // Mean of the block being replayed
	logic          reading;
	logic          at_last;   // Final read address this cycle

	assign reading = (state == REPLAY_READ);
	assign at_last = (rd_addr == ADDR_W'(TOTAL_SAMPLES - 1));

	// Sequencer, busy for exactly TOTAL_SAMPLES cycles per block
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= REPLAY_IDLE;
			rd_addr <= '0;
			rd_bank <= 1'b0;
		end else begin
			case (state)
				REPLAY_IDLE: begin
					if (block_done) begin
						state   <= REPLAY_READ;
						rd_addr <= '0;
						rd_bank <= block_bank; // Read the bank just filled
					end
				end
				REPLAY_READ: begin
					rd_addr <= rd_addr + 1'b1; // Wraps back to 0 at the end
					if (at_last) begin
						if (block_done) begin
							rd_bank <= block_bank; // Back to back block follows
						end else begin
							state <= REPLAY_IDLE;
						end
					end
				end
				default: state <= REPLAY_IDLE;
			endcase
		end
	end

	// Mean is latched with the block, also on the last read of the one before
	always_ff @(posedge clk) begin
		if (block_done && (!reading || at_last)) begin
			held_mean <= block_mean;
		end
	end

	// Tags one cycle behind the read address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			diff_valid <= 1'b0;
			diff_first <= 1'b0;
			diff_last  <= 1'b0;
		end else begin
			diff_valid <= reading;
			diff_first <= reading && (rd_addr == '0);
			diff_last  <= reading && at_last;
		end
	end

	always_ff @(posedge clk) begin
		diff_mean <= held_mean; // Payload, follows the tags
	end

	// Back to back blocks reach the replay no earlier than its final read
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		block_done |-> (state != REPLAY_READ || at_last));

endmodule

/* rtl/sample_bank.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample bank
// Two sample stores of TOTAL_SAMPLES entries. One bank takes the
// incoming block while the other is read back for the variance pass.
// Synchronous write, registered read with one cycle latency.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sample_bank
	import stat_types_pkg::*;
	import stat_ctrl_pkg::*;
#(
	parameter int TOTAL_SAMPLES = 64
) (
	input  logic                             clk,
	input  logic                             wr_en,
	input  bank_t                            wr_bank,
	input  logic [$clog2(TOTAL_SAMPLES)-1:0] wr_addr,
	input  sample_t                          wr_data,
	input  bank_t                            rd_bank,
	input  logic [$clog2(TOTAL_SAMPLES)-1:0] rd_addr,
	output sample_t                          rd_data   // Valid the cycle after rd_addr
);

	sample_t bank0_mem [TOTAL_SAMPLES]; // Even blocks
	sample_t bank1_mem [TOTAL_SAMPLES]; // Odd blocks
	sample_t rd_bank0;                  // Read from each bank before the select
	sample_t rd_bank1;

	// Write port, only the addressed bank changes
	always_ff @(posedge clk) begin
		if (wr_en && (wr_bank == 1'b0)) begin
			bank0_mem[wr_addr] <= wr_data;
		end
		if (wr_en && (wr_bank == 1'b1)) begin
			bank1_mem[wr_addr] <= wr_data;
		end
	end

	// Both banks see the same read address
	assign rd_bank0 = bank0_mem[rd_addr];
	assign rd_bank1 = bank1_mem[rd_addr];

	// Registered read data
	always_ff @(posedge clk) begin
		rd_data <= (rd_bank == 1'b0) ? rd_bank0 : rd_bank1;
	end

endmodule

/* rtl/mean_accumulator.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mean accumulator
// Sums each block of TOTAL_SAMPLES samples and writes them to the
// current bank. On the last sample it registers the mean, pulses
// block_done and flips to the other bank.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mean_accumulator
	import stat_types_pkg::*;
	import stat_ctrl_pkg::*;
#(
	parameter int TOTAL_SAMPLES = 64 // Block length, power of two
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             sample_valid, // Sample accepted this cycle
	input  sample_t                          sample,
	output logic                             wr_en,
	output bank_t                            wr_bank,
	output logic [$clog2(TOTAL_SAMPLES)-1:0] wr_addr,
	output sample_t                          wr_data,
	output logic                             block_done,   // One-cycle pulse
	output mean_t                            block_mean,
	output bank_t                            block_bank    // Bank holding the finished block
);

	localparam int ADDR_W = $clog2(TOTAL_SAMPLES);
	localparam int SUM_W  = SAMPLE_W + ADDR_W; // Holds T * 255

	logic [ADDR_W-1:0] count;    // Samples taken in this block
	logic [SUM_W-1:0]  sum;      // Running block sum
	logic [SUM_W-1:0]  sum_next; // Sum including this cycle's sample
	bank_t             bank;     // Bank being filled
	logic              last;     // Final sample of the block

	// Write port follows the input directly
	assign wr_en   = sample_valid;
	assign wr_bank = bank;
	assign wr_addr = count;      // Count doubles as write address
	assign wr_data = sample;

	assign sum_next = sum + SUM_W'(sample);
	assign last     = sample_valid && (count == ADDR_W'(TOTAL_SAMPLES - 1));

	// Count, sum and bank select
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count      <= '0;
			sum        <= '0;
			bank       <= 1'b0;
			block_done <= 1'b0;
		end else begin
			block_done <= last;
			if (sample_valid) begin
				count <= count + 1'b1; // Wraps to 0 after the last sample
				if (last) begin
					sum  <= '0;     // Next block starts clean
					bank <= ~bank;
				end else begin
					sum <= sum_next;
				end
			end
		end
	end

	// Block results, valid with block_done
	always_ff @(posedge clk) begin
		if (last) begin
			block_mean <= sum_next[SUM_W-1 -: SAMPLE_W]; // Divide by T
			block_bank <= bank;
		end
	end

	// Completion is a single pulse, blocks are at least T cycles apart
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		block_done |=> !block_done);

endmodule

/* rtl/stat_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block statistics control encodings
// Replay sequencer states and the sample bank index.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package stat_ctrl_pkg;

	// Bank index, two banks in ping-pong use
	typedef logic bank_t;

	// Replay sequencer states
	typedef enum logic {
		REPLAY_IDLE = 1'b0, // Waiting for a finished block
		REPLAY_READ = 1'b1  // Stepping through the bank
	} replay_state_e;

endpackage

/* rtl/stat_types_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block statistics data types
// Widths for samples, means, differences, squares and variance results.
// All statistics stages share these so the datapath widths agree.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package stat_types_pkg;

	// Input sample width, unsigned
	localparam int SAMPLE_W = 8;

	// One input sample
	typedef logic [SAMPLE_W-1:0] sample_t;

	// Block mean, same range as a sample
	typedef logic [SAMPLE_W-1:0] mean_t;

	// Sample minus mean, one extra bit for sign
	// Range is -255 to +255
	typedef logic signed [SAMPLE_W:0] diff_t;

	// Squared difference
	// 255 * 255 = 65025 still fits in 16 bits
	typedef logic [2*SAMPLE_W-1:0] square_t;

	// Block variance, never above the largest square
	typedef logic [2*SAMPLE_W-1:0] var_t;

endpackage
